/* src.f */
rtl/fetch_pkg.sv
rtl/fetch_word_if.sv
rtl/fetch_requester.sv
rtl/fetch_queue.sv
rtl/inst_realigner.sv
rtl/zc_expander.sv
rtl/if_stage.sv
dv/clk_rst_gen.sv
dv/tb_if_stage.sv

/* Bender.yml */
package:
  name: if_stage

sources:
  - files:
      - rtl/fetch_pkg.sv
      - rtl/fetch_word_if.sv
      - rtl/fetch_requester.sv
      - rtl/fetch_queue.sv
      - rtl/inst_realigner.sv
      - rtl/zc_expander.sv
      - rtl/if_stage.sv
  - target: simulation
    files:
      - dv/clk_rst_gen.sv
      - dv/tb_if_stage.sv

/* dv/tb_if_stage.sv */
`timescale 1ns/1ps

module tb_if_stage;

  localparam int QUEUE_DEPTH = 4;
  localparam int TABLE_BYTES = 32;
  localparam int WAIT_LIMIT  = 2000;

  logic             clk;
  logic             arst_n;
  logic             mem_req;
  fetch_pkg::addr_t mem_addr;
  logic             mem_rvalid;
  fetch_pkg::inst_t mem_rdata;
  logic             stall;
  logic             redirect;
  fetch_pkg::addr_t redirect_pc;
  logic             out_valid;
  fetch_pkg::inst_t out_inst;
  fetch_pkg::addr_t out_pc;
  logic             out_is_compressed;
  logic             out_illegal;

  // program halfwords and hand-written expectations per halfword pc
  fetch_pkg::half_t prog      [TABLE_BYTES/2];
  fetch_pkg::inst_t exp_inst  [TABLE_BYTES/2];
  logic             exp_ill   [TABLE_BYTES/2];
  logic             exp_cmp   [TABLE_BYTES/2];
  logic             exp_start [TABLE_BYTES/2];

  fetch_pkg::inst_t cur_inst;
  logic             cur_ill;
  logic             cur_cmp;
  logic             cur_start;

  fetch_pkg::addr_t req_addr_q [$];
  int unsigned      req_due_q  [$];
  int unsigned      cyc;
  int unsigned      last_due;
  int unsigned      lat;
  int unsigned      due;

  int               err_cnt;
  int               deliveries;
  string            test_name;
  logic             completed;
  fetch_pkg::addr_t next_pc_q;
  logic             held_q;
  int               stall_reqs_q;

  clk_rst_gen clk_rst_i (
    .clk   (clk),
    .arst_n(arst_n)
  );

  if_stage #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) dut_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .mem_req          (mem_req),
    .mem_addr         (mem_addr),
    .mem_rvalid       (mem_rvalid),
    .mem_rdata        (mem_rdata),
    .stall            (stall),
    .redirect         (redirect),
    .redirect_pc      (redirect_pc),
    .out_valid        (out_valid),
    .out_inst         (out_inst),
    .out_pc           (out_pc),
    .out_is_compressed(out_is_compressed),
    .out_illegal      (out_illegal)
  );

  function automatic fetch_pkg::inst_t word_at(input fetch_pkg::addr_t a);
    if (a < TABLE_BYTES) begin
      return {prog[{a[4:2], 1'b1}], prog[{a[4:2], 1'b0}]};
    end else begin
      // past the table every word is a 32-bit instruction built from its address
      return {a[31:2], 2'b11};
    end
  endfunction

  task automatic put_c(input int pc, input fetch_pkg::half_t h, input fetch_pkg::inst_t e,
                       input logic ill);
    prog[pc/2]      = h;
    exp_inst[pc/2]  = e;
    exp_ill[pc/2]   = ill;
    exp_cmp[pc/2]   = 1'b1;
    exp_start[pc/2] = 1'b1;
  endtask

  task automatic put_w(input int pc, input fetch_pkg::inst_t w);
    prog[pc/2]      = w[15:0];
    prog[pc/2+1]    = w[31:16];
    exp_inst[pc/2]  = w;
    exp_ill[pc/2]   = 1'b0;
    exp_cmp[pc/2]   = 1'b0;
    exp_start[pc/2] = 1'b1;
  endtask

  initial begin
    for (int i = 0; i < TABLE_BYTES/2; i++) begin
      exp_start[i] = 1'b0;
    end
    put_c(0,  16'h0405, 32'h00140413, 1'b0);  // c.addi x8, 1
    put_w(2,  32'h007302b3);                  // add x5, x6, x7 across words
    put_c(6,  16'h4144, 32'h00452483, 1'b0);  // c.lw x9, 4(x10)
    put_c(8,  16'ha021, 32'h0080006f, 1'b0);  // c.j +8
    put_c(10, 16'h85b2, 32'h00c005b3, 1'b0);  // c.mv x11, x12
    put_c(12, 16'h8144, 32'h00154483, 1'b0);  // c.lbu x9, 1(x10)
    put_c(14, 16'h8c05, 32'h40940433, 1'b0);  // c.sub x8, x9
    put_c(16, 16'h9c61, 32'h0ff47413, 1'b0);  // c.zext.b x8
    put_c(18, 16'hc011, 32'h00040263, 1'b0);  // c.beqz x8, +4
    put_c(20, 16'h0000, 32'h0, 1'b1);         // all-zero halfword
    put_c(22, 16'h4002, 32'h0, 1'b1);         // c.lwsp with rd = x0
    put_c(24, 16'h9c69, 32'h0, 1'b1);         // c.zext.h needs zbb
    put_w(26, 32'h123450b7);                  // lui x1 across words
    put_c(30, 16'h0001, 32'h00000013, 1'b0);  // c.nop
  end

  always @* begin
    if (out_pc < TABLE_BYTES) begin
      cur_inst  = exp_inst[out_pc[4:1]];
      cur_ill   = exp_ill[out_pc[4:1]];
      cur_cmp   = exp_cmp[out_pc[4:1]];
      cur_start = exp_start[out_pc[4:1]];
    end else begin
      cur_inst  = word_at(out_pc);
      cur_ill   = 1'b0;
      cur_cmp   = 1'b0;
      cur_start = (out_pc[1:0] == 2'b00);
    end
  end

  // memory model, in-order responses after 1..4 cycles, one per cycle
  always @(negedge clk) begin
    if (arst_n && mem_req) begin
      lat = 1 + ($urandom % 4);
      due = cyc + lat;
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      req_addr_q.push_back(mem_addr);
      req_due_q.push_back(due);
    end
  end

  always @(posedge clk) begin
    cyc = cyc + 1;
    #1;
    if (req_due_q.size() > 0 && req_due_q[0] == cyc) begin
      void'(req_due_q.pop_front());
      mem_rdata  = word_at(req_addr_q.pop_front());
      mem_rvalid = 1'b1;
    end else begin
      mem_rvalid = 1'b0;
    end
  end

  // expected pc of the next new instruction, and stall bookkeeping
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      next_pc_q    <= '0;
      held_q       <= 1'b0;
      stall_reqs_q <= 0;
      deliveries   <= 0;
    end else begin
      held_q <= out_valid && stall && !redirect;
      if (redirect) begin
        next_pc_q <= redirect_pc;
      end else if (out_valid && !stall) begin
        next_pc_q <= out_pc + (cur_cmp ? 32'd2 : 32'd4);
      end
      if (out_valid && !held_q) begin
        deliveries <= deliveries + 1;
      end
      if (!stall) begin
        stall_reqs_q <= 0;
      end else if (mem_req) begin
        stall_reqs_q <= stall_reqs_q + 1;
      end
    end
  end

  inst_matches: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && cur_start && !cur_ill |-> out_inst == cur_inst)
    else begin
      err_cnt++;
      $display("ERROR %s: inst at pc %h expected %h actual %h", test_name, out_pc, cur_inst,
               out_inst);
    end

  flags_match: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && cur_start |-> out_illegal == cur_ill && out_is_compressed == cur_cmp)
    else begin
      err_cnt++;
      $display("ERROR %s: illegal/compressed at pc %h expected %b%b actual %b%b", test_name,
               out_pc, cur_ill, cur_cmp, out_illegal, out_is_compressed);
    end

  pc_is_instruction_start: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> cur_start)
    else begin
      err_cnt++;
      $display("%s: pc %h is not the start of any instruction", test_name, out_pc);
    end

  pc_follows: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !held_q |-> out_pc == next_pc_q)
    else begin
      err_cnt++;
      $display("ERROR %s: next pc expected %h actual %h", test_name, next_pc_q, out_pc);
    end

  stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && stall && !redirect |=> out_valid && $stable(out_inst) && $stable(out_pc))
    else begin
      err_cnt++;
      $display("ERROR %s: held output expected pc %h actual %h", test_name, $past(out_pc),
               out_pc);
    end

  stall_credit_limit: assert property (@(posedge clk) disable iff (!arst_n)
    stall && mem_req |-> stall_reqs_q < QUEUE_DEPTH)
    else begin
      err_cnt++;
      $display("%s: more than %0d requests issued during a stall", test_name, QUEUE_DEPTH);
    end

  task automatic wait_for_pc(input fetch_pkg::addr_t pc, output logic found);
    int n;
    found = 1'b0;
    n     = 0;
    while (!found && n < WAIT_LIMIT) begin
      @(posedge clk);
      found = out_valid && (out_pc == pc);
      n++;
    end
    if (!found) begin
      $display("%s: timed out waiting for an instruction at pc %h", test_name, pc);
    end
  endtask

  task automatic wait_reset(output logic found);
    int n;
    found = 1'b0;
    n     = 0;
    while (!found && n < WAIT_LIMIT) begin
      @(posedge clk);
      found = arst_n;
      n++;
    end
    if (!found) begin
      $display("reset was never released");
    end
  endtask

  // one-cycle redirect pulse, any stall is released along with it
  task automatic redirect_to(input fetch_pkg::addr_t pc);
    @(posedge clk);
    #1;
    redirect    = 1'b1;
    redirect_pc = pc;
    @(posedge clk);
    #1;
    redirect = 1'b0;
    stall    = 1'b0;
  endtask

  task automatic run_sequence(output logic done);
    logic ok;
    done      = 1'b0;
    test_name = "reset";
    wait_reset(ok);
    if (!ok) return;
    test_name = "straight_line";
    wait_for_pc(32'd30, ok);
    if (!ok) return;
    test_name = "stall";
    @(posedge clk);
    #1;
    stall = 1'b1;
    repeat (20) @(posedge clk);
    #1;
    stall = 1'b0;
    wait_for_pc(32'd40, ok);
    if (!ok) return;
    test_name = "redirect_even";
    redirect_to(32'd8);
    wait_for_pc(32'd8, ok);
    if (!ok) return;
    wait_for_pc(32'd30, ok);
    if (!ok) return;
    // odd target, issued while the core is stalled
    test_name = "redirect_odd";
    @(posedge clk);
    #1;
    stall = 1'b1;
    repeat (3) @(posedge clk);
    redirect_to(32'd26);
    wait_for_pc(32'd26, ok);
    if (!ok) return;
    wait_for_pc(32'd44, ok);
    if (!ok) return;
    done = 1'b1;
  endtask

  initial begin
    void'($urandom(32'h8eb5));
    stall       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    mem_rvalid  = 1'b0;
    mem_rdata   = '0;
    cyc         = 0;
    last_due    = 0;
    err_cnt     = 0;
    run_sequence(completed);
    $display("run finished: %0d instructions delivered, %0d errors, sequence %s", deliveries,
             err_cnt, completed ? "complete" : "incomplete");
    if (err_cnt == 0 && completed) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

/* dv/clk_rst_gen.sv */
`timescale 1ns/1ps

// free-running testbench clock and an active-low reset held for a few cycles
module clk_rst_gen #(
  parameter real PERIOD_NS    = 10.0,
  parameter int  RESET_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // release just after an edge so the first active edge is clean
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    arst_n = 1'b1;
  end

endmodule

/* rtl/if_stage.sv */
`timescale 1ns/1ps

module if_stage #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic             clk,
  input  logic             arst_n,
  output logic             mem_req,
  output fetch_pkg::addr_t mem_addr,
  input  logic             mem_rvalid,
  input  fetch_pkg::inst_t mem_rdata,
  input  logic             stall,
  input  logic             redirect,
  input  fetch_pkg::addr_t redirect_pc,
  output logic             out_valid,
  output fetch_pkg::inst_t out_inst,
  output fetch_pkg::addr_t out_pc,
  output logic             out_is_compressed,
  output logic             out_illegal
);

  logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count;
  logic                             push;
  fetch_pkg::addr_t                 push_addr;
  fetch_pkg::inst_t                 raw_inst;

  fetch_word_if word_if ();

  fetch_requester #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) requester_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .mem_rvalid (mem_rvalid),
    .queue_count(queue_count),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .push       (push),
    .push_addr  (push_addr)
  );

  // a redirect drops every queued word of the old path
  fetch_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) queue_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .flush    (redirect),
    .push     (push),
    .push_word(mem_rdata),
    .push_addr(push_addr),
    .count    (queue_count),
    .deq      (word_if)
  );

  inst_realigner realigner_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (stall),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .src        (word_if),
    .out_valid  (out_valid),
    .raw_inst   (raw_inst),
    .out_pc     (out_pc)
  );

  // expansion sits behind the realigner's output register
  zc_expander expander_i (
    .zc_val(raw_inst),
    .inst  (out_inst),
    .is_zc (out_is_compressed),
    .zc_err(out_illegal)
  );

endmodule

/* rtl/zc_expander.sv */
`timescale 1ns/1ps

module zc_expander (
  input  fetch_pkg::inst_t zc_val,
  output fetch_pkg::inst_t inst,
  output logic             is_zc,
  output logic             zc_err
);

  fetch_pkg::half_t c;
  logic [4:0]       rd;
  logic [4:0]       rs2;
  logic [4:0]       rp_lo;
  logic [4:0]       rp_hi;
  logic [11:0]      j_off;
  logic [2:0]       alu_f3;

  assign c     = zc_val[15:0];
  assign rd    = c[11:7];
  assign rs2   = c[6:2];
  // 3-bit register fields address x8..x15
  assign rp_lo = {2'b01, c[4:2]};
  assign rp_hi = {2'b01, c[9:7]};
  // c.j / c.jal offset, bit 0 always clear
  assign j_off = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
  // sub/xor/or/and funct3 from c[6:5]: 000, 100, 110, 111
  assign alu_f3 = {|c[6:5], c[6], &c[6:5]};

  assign is_zc = (zc_val[1:0] != 2'b11);

  always_comb begin
    inst   = zc_val;
    zc_err = 1'b0;

    case (c[1:0])
      2'b00: begin
        case (c[15:13])
          3'b000: begin
            // c.addi4spn
            inst   = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, 3'b000, rp_lo,
                      fetch_pkg::OP_IMM};
            zc_err = (c[12:5] == 8'h00);
          end
          3'b010: begin
            inst = {5'b0, c[5], c[12:10], c[6], 2'b00, rp_hi, 3'b010, rp_lo, fetch_pkg::LOAD};
          end
          3'b100: begin
            // zcb byte and halfword loads/stores
            case (c[12:10])
              3'b000: inst = {10'b0, c[5], c[6], rp_hi, 3'b100, rp_lo, fetch_pkg::LOAD};
              3'b001: begin
                // c[6] picks c.lh over c.lhu
                inst = {10'b0, c[5], 1'b0, rp_hi, ~c[6], 2'b01, rp_lo, fetch_pkg::LOAD};
              end
              3'b010: inst = {7'b0, rp_lo, rp_hi, 3'b000, 3'b000, c[5], c[6], fetch_pkg::STORE};
              3'b011: begin
                inst   = {7'b0, rp_lo, rp_hi, 3'b001, 3'b000, c[5], 1'b0, fetch_pkg::STORE};
                zc_err = c[6];
              end
              default: zc_err = 1'b1;
            endcase
          end
          3'b110: begin
            inst = {5'b0, c[5], c[12], rp_lo, rp_hi, 3'b010, c[11:10], c[6], 2'b00,
                    fetch_pkg::STORE};
          end
          default: zc_err = 1'b1;
        endcase
      end

      2'b01: begin
        case (c[15:13])
          3'b000: inst = {{7{c[12]}}, rs2, rd, 3'b000, rd, fetch_pkg::OP_IMM};
          // c.jal links x1, c.j links x0
          3'b001, 3'b101: begin
            inst = {j_off[11], j_off[10:1], j_off[11], {8{j_off[11]}}, 4'b0000, ~c[15],
                    fetch_pkg::JAL};
          end
          3'b010: inst = {{7{c[12]}}, rs2, 5'd0, 3'b000, rd, fetch_pkg::OP_IMM};
          3'b011: begin
            if (rd == 5'd2) begin
              // c.addi16sp
              inst = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000, 5'd2, 3'b000, 5'd2,
                      fetch_pkg::OP_IMM};
            end else begin
              inst = {{15{c[12]}}, rs2, rd, fetch_pkg::LUI};
            end
            zc_err = ({c[12], rs2} == 6'b0);
          end
          3'b100: begin
            case (c[11:10])
              2'b00, 2'b01: begin
                // srli / srai, shamt[5] must be clear on rv32
                inst   = {1'b0, c[10], 5'b0, rs2, rp_hi, 3'b101, rp_hi, fetch_pkg::OP_IMM};
                zc_err = c[12];
              end
              2'b10: inst = {{7{c[12]}}, rs2, rp_hi, 3'b111, rp_hi, fetch_pkg::OP_IMM};
              default: begin
                case ({c[12], c[6:5]})
                  3'b000, 3'b001, 3'b010, 3'b011: begin
                    inst = {1'b0, ~|c[6:5], 5'b0, rp_lo, rp_hi, alu_f3, rp_hi, fetch_pkg::OP};
                  end
                  3'b110: inst = {7'b0000001, rp_lo, rp_hi, 3'b000, rp_hi, fetch_pkg::OP};
                  3'b111: begin
                    // only c.zext.b and c.not exist without zbb
                    case (c[4:2])
                      3'b000: inst = {12'h0ff, rp_hi, 3'b111, rp_hi, fetch_pkg::OP_IMM};
                      3'b101: inst = {12'hfff, rp_hi, 3'b100, rp_hi, fetch_pkg::OP_IMM};
                      default: zc_err = 1'b1;
                    endcase
                  end
                  default: zc_err = 1'b1;
                endcase
              end
            endcase
          end
          // c.beqz / c.bnez, funct3 bit 0 from c[13]
          default: begin
            inst = {{4{c[12]}}, c[6:5], c[2], 5'd0, rp_hi, 2'b00, c[13], c[11:10], c[4:3],
                    c[12], fetch_pkg::BRANCH};
          end
        endcase
      end

      2'b10: begin
        case (c[15:13])
          3'b000: begin
            inst   = {7'b0, rs2, rd, 3'b001, rd, fetch_pkg::OP_IMM};
            zc_err = c[12];
          end
          3'b010: begin
            inst   = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, rd, fetch_pkg::LOAD};
            zc_err = (rd == 5'd0);
          end
          3'b100: begin
            if (rs2 != 5'd0) begin
              // c.mv adds to x0, c.add to rd
              inst = {7'b0, rs2, rd & {5{c[12]}}, 3'b000, rd, fetch_pkg::OP};
            end else if (!c[12]) begin
              inst   = {12'h000, rd, 3'b000, 5'd0, fetch_pkg::JALR};
              zc_err = (rd == 5'd0);
            end else if (rd == 5'd0) begin
              inst = 32'h0010_0073;
            end else begin
              inst = {12'h000, rd, 3'b000, 5'd1, fetch_pkg::JALR};
            end
          end
          3'b110: begin
            inst = {4'b0, c[8:7], c[12], rs2, 5'd2, 3'b010, c[11:9], 2'b00, fetch_pkg::STORE};
          end
          default: zc_err = 1'b1;
        endcase
      end

      // full-size instruction, passed through
      default: ;
    endcase
  end

endmodule

/* rtl/inst_realigner.sv */
`timescale 1ns/1ps

module inst_realigner (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             stall,
  input  logic             redirect,
  input  fetch_pkg::addr_t redirect_pc,
  fetch_word_if.realigner  src,
  output logic             out_valid,
  output fetch_pkg::inst_t raw_inst,
  output fetch_pkg::addr_t out_pc
);

  fetch_pkg::realign_state_e state_q;
  fetch_pkg::realign_state_e state_d;
  fetch_pkg::half_t          left_q;
  fetch_pkg::half_t          left_d;
  fetch_pkg::addr_t          left_pc_q;
  fetch_pkg::addr_t          left_pc_d;
  fetch_pkg::half_t          word_lo;
  fetch_pkg::half_t          word_hi;
  fetch_pkg::inst_t          emit_inst;
  fetch_pkg::addr_t          emit_pc;
  logic                      emit;
  logic                      take;
  logic                      advance;

  assign word_lo = src.word[15:0];
  assign word_hi = src.word[31:16];
  assign advance = !redirect && !stall;
  assign src.pop = take && advance;

  always_comb begin
    state_d   = state_q;
    left_d    = left_q;
    left_pc_d = left_pc_q;
    emit      = 1'b0;
    take      = 1'b0;
    emit_inst = src.word;
    emit_pc   = src.addr;

    case (state_q)
      fetch_pkg::RA_EMPTY: begin
        if (src.valid) begin
          take = 1'b1;
          emit = 1'b1;
          // compressed low half, keep the upper half for the next cycle
          if (word_lo[1:0] != 2'b11) begin
            emit_inst = {16'h0000, word_lo};
            left_d    = word_hi;
            left_pc_d = src.addr + 32'd2;
            state_d   = fetch_pkg::RA_HALF;
          end
        end
      end

      fetch_pkg::RA_HALF: begin
        if (left_q[1:0] != 2'b11) begin
          emit      = 1'b1;
          emit_inst = {16'h0000, left_q};
          emit_pc   = left_pc_q;
          state_d   = fetch_pkg::RA_EMPTY;
        end else if (src.valid) begin
          // 32-bit instruction straddling the word boundary
          take      = 1'b1;
          emit      = 1'b1;
          emit_inst = {word_lo, left_q};
          emit_pc   = left_pc_q;
          left_d    = word_hi;
          left_pc_d = src.addr + 32'd2;
        end
      end

      fetch_pkg::RA_SKIP_LO: begin
        if (src.valid) begin
          take = 1'b1;
          if (word_hi[1:0] != 2'b11) begin
            emit      = 1'b1;
            emit_inst = {16'h0000, word_hi};
            emit_pc   = src.addr + 32'd2;
            state_d   = fetch_pkg::RA_EMPTY;
          end else begin
            left_d    = word_hi;
            left_pc_d = src.addr + 32'd2;
            state_d   = fetch_pkg::RA_HALF;
          end
        end
      end

      default: begin
        state_d = fetch_pkg::RA_EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q   <= fetch_pkg::RA_EMPTY;
      out_valid <= 1'b0;
    end else if (redirect) begin
      state_q   <= redirect_pc[1] ? fetch_pkg::RA_SKIP_LO : fetch_pkg::RA_EMPTY;
      out_valid <= 1'b0;
    end else if (!stall) begin
      state_q   <= state_d;
      out_valid <= emit;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      left_q    <= left_d;
      left_pc_q <= left_pc_d;
      if (emit) begin
        raw_inst <= emit_inst;
        out_pc   <= emit_pc;
      end
    end
  end

endmodule

/* rtl/fetch_queue.sv */
`timescale 1ns/1ps

module fetch_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             flush,
  input  logic                             push,
  input  fetch_pkg::inst_t                 push_word,
  input  fetch_pkg::addr_t                 push_addr,
  output logic [$clog2(QUEUE_DEPTH+1)-1:0] count,
  fetch_word_if.queue                      deq
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  fetch_pkg::inst_t word_mem [QUEUE_DEPTH];
  fetch_pkg::addr_t addr_mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic             do_pop;

  // head entry is presented straight from storage
  assign deq.valid = (count != '0);
  assign deq.word  = word_mem[rd_ptr_q];
  assign deq.addr  = addr_mem[rd_ptr_q];

  assign do_pop = deq.pop && deq.valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count    <= '0;
    end else if (flush) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count <= count + CNT_W'(push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push && !flush) begin
      word_mem[wr_ptr_q] <= push_word;
      addr_mem[wr_ptr_q] <= push_addr;
    end
  end

  // the requester's credit limit keeps the queue from overflowing
  no_push_when_full: assert property (@(posedge clk) disable iff (!arst_n)
    push && !flush |-> count < CNT_W'(QUEUE_DEPTH));

endmodule

/* rtl/fetch_requester.sv */
`timescale 1ns/1ps

module fetch_requester #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                             clk,
  input  logic                             arst_n,
  input  logic                             redirect,
  input  fetch_pkg::addr_t                 redirect_pc,
  input  logic                             mem_rvalid,
  input  logic [$clog2(QUEUE_DEPTH+1)-1:0] queue_count,
  output logic                             mem_req,
  output fetch_pkg::addr_t                 mem_addr,
  output logic                             push,
  output fetch_pkg::addr_t                 push_addr
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  logic [CNT_W-1:0] outstanding_q;
  logic [CNT_W-1:0] stale_q;
  logic [CNT_W:0]   credit_used;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic             rsp_stale;

  // address of every request in flight, oldest at rd_ptr_q
  fetch_pkg::addr_t addr_fifo [QUEUE_DEPTH];

  // words in flight plus words already queued must fit the queue
  assign credit_used = {1'b0, outstanding_q} + {1'b0, queue_count};
  assign mem_req     = !redirect && (credit_used < (CNT_W + 1)'(QUEUE_DEPTH));

  // responses to requests issued before a redirect are dropped
  assign rsp_stale = (stale_q != '0);
  assign push      = mem_rvalid && !rsp_stale && !redirect;
  assign push_addr = addr_fifo[rd_ptr_q];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_addr      <= '0;
      outstanding_q <= '0;
      stale_q       <= '0;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
    end else begin
      if (redirect) begin
        mem_addr <= {redirect_pc[31:2], 2'b00};
      end else if (mem_req) begin
        mem_addr <= mem_addr + 32'd4;
      end

      outstanding_q <= outstanding_q + CNT_W'(mem_req) - CNT_W'(mem_rvalid);

      // everything still outstanding after this cycle belongs to the old path
      if (redirect) begin
        stale_q <= outstanding_q - CNT_W'(mem_rvalid);
      end else if (mem_rvalid && rsp_stale) begin
        stale_q <= stale_q - 1'b1;
      end

      if (mem_req) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (mem_rvalid) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req) begin
      addr_fifo[wr_ptr_q] <= mem_addr;
    end
  end

  // memory must answer only requests that were actually issued
  rvalid_has_request: assert property (@(posedge clk) disable iff (!arst_n)
    mem_rvalid |-> outstanding_q != '0);

  fetch_addr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
    mem_addr[1:0] == 2'b00);

endmodule

/* rtl/fetch_word_if.sv */
`timescale 1ns/1ps

// queued fetch words from the FIFO head to the realigner
interface fetch_word_if;
  logic             valid;
  fetch_pkg::inst_t word;
  fetch_pkg::addr_t addr;
  // removes the head word at the clock edge, only while valid
  logic             pop;

  modport queue (
    output valid,
    output word,
    output addr,
    input  pop
  );

  modport realigner (
    input  valid,
    input  word,
    input  addr,
    output pop
  );
endinterface

/* rtl/fetch_pkg.sv */
package fetch_pkg;

  // rv32 major opcodes used when building expanded instructions
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LOAD   = 7'b0000011;
  localparam logic [6:0] STORE  = 7'b0100011;
  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] JALR   = 7'b1100111;
  localparam logic [6:0] BRANCH = 7'b1100011;

  // full instruction word, also the memory data width
  typedef logic [31:0] inst_t;

  // one parcel of the instruction stream
  typedef logic [15:0] half_t;

  // byte address
  typedef logic [31:0] addr_t;

  // realigner states
  typedef enum logic [1:0] {
    // nothing held over from the previous word
    RA_EMPTY,
    // upper half of the previous word still pending
    RA_HALF,
    // odd redirect target, low half of next word is dropped
    RA_SKIP_LO
  } realign_state_e;

endpackage
